// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --timing --assert --timescale 1ns/1ps
TOP       = ps2_keyboard_rx_tb
FILELIST  = sim.f
BUILD_DIR = obj_dir
PASS_MSG  = All checks passed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# the run passes only if the pass line shows up in the output
sim: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== sim.f ====
verilog/ps2_line_pkg.sv
verilog/scan_code_pkg.sv
verilog/ps2_rx_fsm.sv
verilog/ps2_bit_timer.sv
verilog/ps2_frame_shifter.sv
verilog/scan_code_ascii.sv
verilog/scan_code_tracker.sv
verilog/ps2_keyboard_rx.sv
sim/ps2_keyboard_rx_checker.sv
sim/ps2_keyboard_rx_tb.sv

// ==== sim/ps2_keyboard_rx_checker.sv ====
`timescale 1ns/1ps

module ps2_keyboard_rx_checker
(
  input logic                      clk,
  input logic                      reset,
  input logic                      rx_read,
  input logic                      rx_extended,
  input logic                      rx_released,
  input scan_code_pkg::scan_code_t rx_scan_code,
  input scan_code_pkg::ascii_t     rx_ascii,
  input logic                      rx_data_ready
);

  // ready drops only on a host read
  ready_falls_on_read : assert property (@(posedge clk) disable iff (reset)
    $fell(rx_data_ready) |-> $past(rx_read))
    else $error("rx_data_ready fell with no rx_read in the cycle before");

  // shift state is left out, a trapped shift key moves it silently
  outputs_move_with_ready : assert property (@(posedge clk) disable iff (reset)
    !$stable({rx_extended, rx_released, rx_scan_code, rx_ascii}) |-> rx_data_ready)
    else $error("outputs changed while rx_data_ready stayed low");

  idle_after_reset : assert property (@(posedge clk) reset |=> !rx_data_ready)
    else $error("rx_data_ready high right after reset");

endmodule

bind ps2_keyboard_rx ps2_keyboard_rx_checker u_checker
(
  .clk           (clk),
  .reset         (reset),
  .rx_read       (rx_read),
  .rx_extended   (rx_extended),
  .rx_released   (rx_released),
  .rx_scan_code  (rx_scan_code),
  .rx_ascii      (rx_ascii),
  .rx_data_ready (rx_data_ready)
);

// ==== sim/ps2_keyboard_rx_tb.sv ====
`timescale 1ns/1ps

module ps2_keyboard_rx_tb;

  import ps2_line_pkg::*;
  import scan_code_pkg::*;

  // one row of the stimulus table
  typedef struct {
    string      name;
    int         num_codes;     // bytes sent in this entry
    scan_code_t codes [3];
    int         partial_bits;  // broken frame sent ahead, 0 for none
    logic       expect_data;   // a key code reaches the outputs
    scan_code_t exp_code;
    ascii_t     exp_ascii;
    logic       exp_extended;
    logic       exp_released;
    logic       exp_shift;
    logic       do_read;       // pulse rx_read after the checks
  } stim_entry_t;

  logic        clk;
  logic        reset;
  logic        ps2_clk;
  logic        ps2_data;
  logic        rx_read;
  logic        rx_extended;
  logic        rx_released;
  logic        rx_shift_key_on;
  scan_code_t  rx_scan_code;
  ascii_t      rx_ascii;
  logic        rx_data_ready;

  stim_entry_t table_q [$];
  int          errors     = 0;
  int          checks     = 0;
  bit          timed_out  = 1'b0;
  logic [31:0] lfsr_state = 32'hf576_b7b1;

  ps2_keyboard_rx #(.WATCHDOG_CYCLES(40), .TRAP_SHIFT_KEYS(1)) DUT
  (
    .clk             (clk),
    .reset           (reset),
    .ps2_clk         (ps2_clk),
    .ps2_data        (ps2_data),
    .rx_read         (rx_read),
    .rx_extended     (rx_extended),
    .rx_released     (rx_released),
    .rx_shift_key_on (rx_shift_key_on),
    .rx_scan_code    (rx_scan_code),
    .rx_ascii        (rx_ascii),
    .rx_data_ready   (rx_data_ready)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;  // 100 MHz
  end

  //----------------------------------------------------------------------
  // helpers
  //----------------------------------------------------------------------

  // inputs always move 1 ns after the rising edge
  task automatic wait_cycles(input int n);
    repeat (n)
    begin
      @(posedge clk);
      #1;
    end
  endtask

  // galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    logic [31:0] stepped;
    stepped = state >> 1;
    if (state[0])
      stepped = stepped ^ 32'h8020_0003;
    return stepped;
  endfunction

  task automatic draw_bits(input int nbits, output int value);
    value = 0;
    for (int i = 0; i < nbits; i++)
    begin
      lfsr_state = lfsr_step(lfsr_state);
      value      = (value << 1) | int'(lfsr_state[0]);  // one step per bit
    end
  endtask

  // keyboard model with 8 cycles per clock half and data moving while the clock is high
  task automatic send_bits(input scan_code_t code, input int nbits);
    ps2_frame_u frame;
    frame.field.start  = 1'b0;
    frame.field.data   = code;
    frame.field.parity = ~^code;  // odd parity
    frame.field.stop   = 1'b1;
    for (int i = 0; i < nbits; i++)
    begin
      ps2_data = frame.raw[i];    // lsb first
      wait_cycles(8);
      ps2_clk = 1'b0;
      wait_cycles(8);
      ps2_clk = 1'b1;
    end
  endtask

  task automatic check_value(input string test, input string what,
                             input logic [7:0] expected, input logic [7:0] actual);
    checks++;
    assert (actual === expected)
    else
    begin
      errors++;
      $display("CHECK FAILED %s %s expected %02h actual %02h", test, what, expected, actual);
    end
  endtask

  task automatic wait_ready(input string test);
    int cycles;
    cycles = 0;
    while (!rx_data_ready && cycles < 2000)
    begin
      wait_cycles(1);
      cycles++;
    end
    if (!rx_data_ready)
    begin
      errors++;
      timed_out = 1'b1;
      $display("%s: rx_data_ready did not rise within 2000 cycles", test);
    end
  endtask

  task automatic add_entry(input string name, input int num_codes,
                           input scan_code_t c0, input scan_code_t c1, input scan_code_t c2,
                           input int partial_bits, input logic expect_data,
                           input scan_code_t exp_code, input ascii_t exp_ascii,
                           input logic exp_extended, input logic exp_released,
                           input logic exp_shift, input logic do_read);
    stim_entry_t e;
    e.name         = name;
    e.num_codes    = num_codes;
    e.codes[0]     = c0;
    e.codes[1]     = c1;
    e.codes[2]     = c2;
    e.partial_bits = partial_bits;
    e.expect_data  = expect_data;
    e.exp_code     = exp_code;
    e.exp_ascii    = exp_ascii;
    e.exp_extended = exp_extended;
    e.exp_released = exp_released;
    e.exp_shift    = exp_shift;
    e.do_read      = do_read;
    table_q.push_back(e);
  endtask

  //----------------------------------------------------------------------
  // stimulus table
  //----------------------------------------------------------------------
  task automatic build_table();
    add_entry("make_a", 1, 8'h1c, 8'h00, 8'h00, 0, 1'b1, 8'h1c, "a", 1'b0, 1'b0, 1'b0, 1'b1);
    // trapped so only the shift state moves
    add_entry("shift_make", 1, left_shift_code, 8'h00, 8'h00, 0, 1'b0,
              8'h00, 8'h00, 1'b0, 1'b0, 1'b1, 1'b0);
    add_entry("shifted_a", 1, 8'h1c, 8'h00, 8'h00, 0, 1'b1, 8'h1c, "A", 1'b0, 1'b0, 1'b1, 1'b1);
    add_entry("shift_break", 2, release_code, left_shift_code, 8'h00, 0, 1'b0,
              8'h00, 8'h00, 1'b0, 1'b0, 1'b0, 1'b0);
    add_entry("ext_release_del", 3, extend_code, release_code, 8'h71, 0, 1'b1,
              8'h71, 8'h7f, 1'b1, 1'b1, 1'b0, 1'b1);
    add_entry("plain_after_prefix", 1, 8'h1b, 8'h00, 8'h00, 0, 1'b1,
              8'h1b, "s", 1'b0, 1'b0, 1'b0, 1'b1);
    add_entry("unlisted_code", 1, 8'h05, 8'h00, 8'h00, 0, 1'b1,
              8'h05, ascii_unlisted, 1'b0, 1'b0, 1'b0, 1'b1);
    add_entry("watchdog_space", 1, 8'h29, 8'h00, 8'h00, 4, 1'b1,
              8'h29, " ", 1'b0, 1'b0, 1'b0, 1'b1);
    // right shift stays held into the reset at the end
    add_entry("right_shift_make", 1, right_shift_code, 8'h00, 8'h00, 0, 1'b0,
              8'h00, 8'h00, 1'b0, 1'b0, 1'b1, 1'b0);
    // no reads so the second code overwrites the first
    add_entry("overrun_first", 1, 8'h16, 8'h00, 8'h00, 0, 1'b1,
              8'h16, "!", 1'b0, 1'b0, 1'b1, 1'b0);
    add_entry("overrun_second", 3, extend_code, release_code, 8'h1e, 0, 1'b1,
              8'h1e, 8'h22, 1'b1, 1'b1, 1'b1, 1'b0);
  endtask

  task automatic run_entry(input stim_entry_t e);
    int gap;
    draw_bits(4, gap);  // 0 to 15 idle cycles
    wait_cycles(gap);
    if (e.partial_bits > 0)
    begin
      send_bits(8'hff, e.partial_bits);
      wait_cycles(60);  // well past the watchdog
    end
    for (int k = 0; k < e.num_codes; k++)
    begin
      send_bits(e.codes[k], frame_bits);
      draw_bits(4, gap);
      wait_cycles(gap);
    end
    check_value(e.name, "rx_shift_key_on", 8'(e.exp_shift), 8'(rx_shift_key_on));
    if (!e.expect_data)
      check_value(e.name, "rx_data_ready", 8'h00, 8'(rx_data_ready));  // nothing reported
    else
    begin
      wait_ready(e.name);
      if (!timed_out)
      begin
        check_value(e.name, "rx_scan_code", e.exp_code, rx_scan_code);
        check_value(e.name, "rx_ascii", e.exp_ascii, rx_ascii);
        check_value(e.name, "rx_extended", 8'(e.exp_extended), 8'(rx_extended));
        check_value(e.name, "rx_released", 8'(e.exp_released), 8'(rx_released));
        if (e.do_read)
        begin
          rx_read = 1'b1;
          wait_cycles(1);  // read sampled at this edge
          rx_read = 1'b0;
          check_value(e.name, "rx_data_ready after read", 8'h00, 8'(rx_data_ready));
        end
        else
        begin
          wait_cycles(2);  // no read so the level stays up
          check_value(e.name, "rx_data_ready held", 8'h01, 8'(rx_data_ready));
        end
      end
    end
  endtask

  task automatic check_reset_state();
    reset = 1'b1;
    wait_cycles(3);
    reset = 1'b0;
    check_value("after_reset", "rx_data_ready", 8'h00, 8'(rx_data_ready));
    check_value("after_reset", "rx_extended", 8'h00, 8'(rx_extended));
    check_value("after_reset", "rx_released", 8'h00, 8'(rx_released));
    check_value("after_reset", "rx_shift_key_on", 8'h00, 8'(rx_shift_key_on));
    check_value("after_reset", "rx_scan_code", 8'h00, rx_scan_code);
    check_value("after_reset", "rx_ascii", 8'h00, rx_ascii);
  endtask

  //----------------------------------------------------------------------
  // main sequence
  //----------------------------------------------------------------------
  initial
  begin
    reset    = 1'b1;
    ps2_clk  = 1'b1;  // idle bus
    ps2_data = 1'b1;
    rx_read  = 1'b0;
    build_table();
    repeat (3) @(posedge clk);
    #1;
    reset = 1'b0;
    for (int n = 0; n < table_q.size(); n++)
    begin
      run_entry(table_q[n]);
      if (timed_out)
        break;
    end
    if (!timed_out)
      check_reset_state();
    $display("checks run %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("All checks passed");
    else
      $display("Checks failed");
    $finish;
  end

endmodule

// ==== verilog/ps2_bit_timer.sv ====
`timescale 1ns/1ps

module ps2_bit_timer
#(
  parameter int WATCHDOG_CYCLES = 2950  // clk cycles of idle before a partial frame is dropped
)
(
  input  logic clk,
  input  logic reset,
  input  logic bit_strobe,    // one per received bit
  input  logic watch_enable,  // low during edge markers
  input  logic idle_high,     // keyboard clock held high
  output logic frame_done     // full frame shifted in
);

  import ps2_line_pkg::*;

  // wide enough to hold WATCHDOG_CYCLES-1
  localparam int wd_width = (WATCHDOG_CYCLES > 2) ? $clog2(WATCHDOG_CYCLES) : 1;

  logic [wd_width-1:0] wd_count;
  logic                wd_done;   // watchdog saturated
  bit_count_t          bit_count;

  //----------------------------------------------------------------------
  // watchdog, restarts at every keyboard clock edge
  //----------------------------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (reset || !watch_enable)
      wd_count <= '0;
    else if (!wd_done)
      wd_count <= wd_count + wd_width'(1);  // hold at the top
  end

  assign wd_done = (wd_count == wd_width'(WATCHDOG_CYCLES - 1));

  //----------------------------------------------------------------------
  // bit counter
  //----------------------------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (reset || frame_done)
      bit_count <= '0;                     // frame complete, start over
    else if (wd_done && idle_high)
      bit_count <= '0;                     // keyboard went quiet mid frame
    else if (bit_strobe)
      bit_count <= bit_count + bit_count_t'(1);
  end

  // one cycle only, the count clears on the next edge
  assign frame_done = (bit_count == bit_count_t'(frame_bits));

endmodule

// ==== verilog/ps2_frame_shifter.sv ====
`timescale 1ns/1ps

module ps2_frame_shifter
(
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      bit_strobe,  // sample data_s now
  input  logic                      data_s,      // synchronized data line
  output scan_code_pkg::scan_code_t scan_code    // data byte of the frame
);

  import ps2_line_pkg::*;

  ps2_frame_u frame;

  // bits arrive lsb first, each new bit enters at the top and moves down
  always_ff @(posedge clk)
  begin
    if (reset)
      frame.raw <= '0;  // drop any partial frame
    else if (bit_strobe)
      frame.raw <= {data_s, frame.raw[frame_bits-1:1]};
  end

  // after the 11th bit the start bit sits in bit 0
  assign scan_code = frame.field.data;

endmodule

// ==== verilog/ps2_keyboard_rx.sv ====
`timescale 1ns/1ps

module ps2_keyboard_rx
#(
  parameter int WATCHDOG_CYCLES = 2950,  // about 60 us at 49.152 MHz
  parameter int TRAP_SHIFT_KEYS = 0
)
(
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      ps2_clk,
  input  logic                      ps2_data,
  input  logic                      rx_read,
  output logic                      rx_extended,
  output logic                      rx_released,
  output logic                      rx_shift_key_on,
  output scan_code_pkg::scan_code_t rx_scan_code,
  output scan_code_pkg::ascii_t     rx_ascii,
  output logic                      rx_data_ready
);

  import scan_code_pkg::*;

  logic       bit_strobe;
  logic       watch_enable;
  logic       idle_high;
  logic       data_s;
  logic       frame_done;
  scan_code_t scan_code;   // data byte of the current frame

  //----------------------------------------------------------------------
  // line front end
  //----------------------------------------------------------------------
  ps2_rx_fsm u_fsm
  (
    .clk          (clk),
    .reset        (reset),
    .ps2_clk      (ps2_clk),
    .ps2_data     (ps2_data),
    .bit_strobe   (bit_strobe),
    .watch_enable (watch_enable),
    .idle_high    (idle_high),
    .data_s       (data_s)
  );

  ps2_bit_timer #(.WATCHDOG_CYCLES(WATCHDOG_CYCLES)) u_timer
  (
    .clk          (clk),
    .reset        (reset),
    .bit_strobe   (bit_strobe),
    .watch_enable (watch_enable),
    .idle_high    (idle_high),
    .frame_done   (frame_done)
  );

  ps2_frame_shifter u_shifter
  (
    .clk        (clk),
    .reset      (reset),
    .bit_strobe (bit_strobe),
    .data_s     (data_s),
    .scan_code  (scan_code)
  );

  //----------------------------------------------------------------------
  // scan code handling
  //----------------------------------------------------------------------
  scan_code_tracker #(.TRAP_SHIFT_KEYS(TRAP_SHIFT_KEYS)) u_tracker
  (
    .clk             (clk),
    .reset           (reset),
    .frame_done      (frame_done),
    .scan_code       (scan_code),
    .rx_read         (rx_read),
    .rx_extended     (rx_extended),
    .rx_released     (rx_released),
    .rx_shift_key_on (rx_shift_key_on),
    .rx_scan_code    (rx_scan_code),
    .rx_ascii        (rx_ascii),
    .rx_data_ready   (rx_data_ready)
  );

endmodule

// ==== verilog/ps2_line_pkg.sv ====
package ps2_line_pkg;

  //----------------------------------------------------------------------
  // frame format on the keyboard data line
  //----------------------------------------------------------------------

  localparam int frame_bits = 11;  // start, 8 data, parity, stop

  localparam logic line_idle = 1'b1;  // both lines float high through pullups

  typedef logic [3:0] bit_count_t;  // counts 0 to frame_bits

  // a frame is shifted in lsb first, so the start bit lands in bit 0
  // and the stop bit ends up at the top of the word
  typedef union packed
  {
    logic [frame_bits-1:0] raw;  // shift register view
    struct packed
    {
      logic       stop;    // high on a good frame
      logic       parity;  // odd parity, not checked here
      logic [7:0] data;    // scan code byte, lsb first on the wire
      logic       start;   // low on a good frame
    } field;
  } ps2_frame_u;

endpackage

// ==== verilog/ps2_rx_fsm.sv ====
`timescale 1ns/1ps

module ps2_rx_fsm
(
  input  logic clk,
  input  logic reset,
  input  logic ps2_clk,       // raw keyboard clock
  input  logic ps2_data,      // raw keyboard data
  output logic bit_strobe,    // one cycle per falling keyboard clock edge
  output logic watch_enable,  // watchdog may count
  output logic idle_high,     // keyboard clock sitting high
  output logic data_s         // synchronized data bit
);

  import ps2_line_pkg::*;

  // state encoding, markers last one cycle each
  localparam logic [1:0] st_clk_high  = 2'd0;
  localparam logic [1:0] st_fall_mark = 2'd1;
  localparam logic [1:0] st_clk_low   = 2'd2;
  localparam logic [1:0] st_rise_mark = 2'd3;

  logic       clk_meta;   // first synchronizer stage
  logic       clk_s;      // second stage, safe to decode
  logic       data_meta;
  logic [1:0] state;
  logic [1:0] next_state;

  //----------------------------------------------------------------------
  // two-flop synchronizers on both keyboard lines
  //----------------------------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      clk_meta  <= line_idle;  // start as an idle bus so no false edge is seen
      clk_s     <= line_idle;
      data_meta <= line_idle;
      data_s    <= line_idle;
    end
    else
    begin
      clk_meta  <= ps2_clk;
      clk_s     <= clk_meta;
      data_meta <= ps2_data;
      data_s    <= data_meta;
    end
  end

  //----------------------------------------------------------------------
  // keyboard clock edge tracking
  //----------------------------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (reset)
      state <= st_clk_high;
    else
      state <= next_state;
  end

  always_comb
  begin
    next_state = state;
    case (state)
      st_clk_high  : if (clk_s != line_idle) next_state = st_fall_mark;
      st_fall_mark : next_state = st_clk_low;    // bit is sampled here
      st_clk_low   : if (clk_s == line_idle) next_state = st_rise_mark;
      st_rise_mark : next_state = st_clk_high;
      default      : next_state = st_clk_high;
    endcase
  end

  assign bit_strobe   = (state == st_fall_mark);
  assign watch_enable = (state == st_clk_high) || (state == st_clk_low);  // off in markers
  assign idle_high    = (state == st_clk_high) && (clk_s == line_idle);

endmodule

// ==== verilog/scan_code_ascii.sv ====
`timescale 1ns/1ps

module scan_code_ascii
(
  input  scan_code_pkg::scan_code_t scan_code,
  input  logic                      shift_key_on,  // either shift key held
  output scan_code_pkg::ascii_t     ascii
);

  import scan_code_pkg::*;

  // keys that give the same character with or without shift
  function automatic ascii_t common_ascii(input scan_code_t code);
    case (code)
      8'h66   : common_ascii = 8'h08;  // backspace
      8'h0d   : common_ascii = 8'h09;  // horizontal tab
      8'h5a   : common_ascii = 8'h0d;  // enter
      8'h76   : common_ascii = 8'h1b;  // esc
      8'h29   : common_ascii = 8'h20;  // space
      8'h71   : common_ascii = 8'h7f;  // delete, also keypad DEL
      default : common_ascii = ascii_unlisted;
    endcase
  endfunction

  always_comb
  begin
    if (shift_key_on)
    begin
      //------------------------------------------------------------------
      // shifted characters
      //------------------------------------------------------------------
      case (scan_code)
        8'h16   : ascii = 8'h21;  // !
        8'h1e   : ascii = 8'h22;  // "
        8'h26   : ascii = 8'h23;  // #
        8'h25   : ascii = 8'h24;  // $
        8'h2e   : ascii = 8'h25;  // %
        8'h36   : ascii = 8'h26;  // &
        8'h3d   : ascii = 8'h27;  // '
        8'h3e   : ascii = 8'h28;  // (
        8'h46   : ascii = 8'h29;  // )
        8'h52   : ascii = 8'h2a;  // *
        8'h4c   : ascii = 8'h2b;  // +
        8'h41   : ascii = 8'h3c;  // <
        8'h4e   : ascii = 8'h3d;  // =
        8'h49   : ascii = 8'h3e;  // >
        8'h4a   : ascii = 8'h3f;  // ?
        8'h1c   : ascii = 8'h41;  // A
        8'h32   : ascii = 8'h42;
        8'h21   : ascii = 8'h43;
        8'h23   : ascii = 8'h44;
        8'h24   : ascii = 8'h45;
        8'h2b   : ascii = 8'h46;
        8'h34   : ascii = 8'h47;
        8'h33   : ascii = 8'h48;
        8'h43   : ascii = 8'h49;
        8'h3b   : ascii = 8'h4a;
        8'h42   : ascii = 8'h4b;
        8'h4b   : ascii = 8'h4c;
        8'h3a   : ascii = 8'h4d;
        8'h31   : ascii = 8'h4e;
        8'h44   : ascii = 8'h4f;
        8'h4d   : ascii = 8'h50;
        8'h15   : ascii = 8'h51;
        8'h2d   : ascii = 8'h52;
        8'h1b   : ascii = 8'h53;
        8'h2c   : ascii = 8'h54;
        8'h3c   : ascii = 8'h55;
        8'h2a   : ascii = 8'h56;
        8'h1d   : ascii = 8'h57;
        8'h22   : ascii = 8'h58;
        8'h35   : ascii = 8'h59;
        8'h1a   : ascii = 8'h5a;  // Z
        8'h51   : ascii = 8'h5f;  // _
        8'h54   : ascii = 8'h60;  // `
        8'h5b   : ascii = 8'h7b;  // {
        8'h6a   : ascii = 8'h7c;  // |
        8'h5d   : ascii = 8'h7d;  // }
        8'h55   : ascii = 8'h7e;  // ~
        default : ascii = common_ascii(scan_code);
      endcase
    end
    else
    begin
      //------------------------------------------------------------------
      // unshifted characters
      //------------------------------------------------------------------
      case (scan_code)
        8'h41   : ascii = 8'h2c;  // ,
        8'h4e   : ascii = 8'h2d;  // -
        8'h49   : ascii = 8'h2e;  // .
        8'h4a   : ascii = 8'h2f;  // /
        8'h45   : ascii = 8'h30;  // 0
        8'h16   : ascii = 8'h31;
        8'h1e   : ascii = 8'h32;
        8'h26   : ascii = 8'h33;
        8'h25   : ascii = 8'h34;
        8'h2e   : ascii = 8'h35;
        8'h36   : ascii = 8'h36;
        8'h3d   : ascii = 8'h37;
        8'h3e   : ascii = 8'h38;
        8'h46   : ascii = 8'h39;  // 9
        8'h52   : ascii = 8'h3a;  // :
        8'h4c   : ascii = 8'h3b;  // ;
        8'h54   : ascii = 8'h40;  // @
        8'h5b   : ascii = 8'h5b;  // [
        8'h6a   : ascii = 8'h5c;  // backslash, 102-key position
        8'h51   : ascii = 8'h5c;  // backslash, 104-key position
        8'h5d   : ascii = 8'h5d;  // ]
        8'h55   : ascii = 8'h5e;  // ^
        8'h1c   : ascii = 8'h61;  // a
        8'h32   : ascii = 8'h62;
        8'h21   : ascii = 8'h63;
        8'h23   : ascii = 8'h64;
        8'h24   : ascii = 8'h65;
        8'h2b   : ascii = 8'h66;
        8'h34   : ascii = 8'h67;
        8'h33   : ascii = 8'h68;
        8'h43   : ascii = 8'h69;
        8'h3b   : ascii = 8'h6a;
        8'h42   : ascii = 8'h6b;
        8'h4b   : ascii = 8'h6c;
        8'h3a   : ascii = 8'h6d;
        8'h31   : ascii = 8'h6e;
        8'h44   : ascii = 8'h6f;
        8'h4d   : ascii = 8'h70;
        8'h15   : ascii = 8'h71;
        8'h2d   : ascii = 8'h72;
        8'h1b   : ascii = 8'h73;
        8'h2c   : ascii = 8'h74;
        8'h3c   : ascii = 8'h75;
        8'h2a   : ascii = 8'h76;
        8'h1d   : ascii = 8'h77;
        8'h22   : ascii = 8'h78;
        8'h35   : ascii = 8'h79;
        8'h1a   : ascii = 8'h7a;  // z
        default : ascii = common_ascii(scan_code);
      endcase
    end
  end

endmodule

// ==== verilog/scan_code_pkg.sv ====
package scan_code_pkg;

  //----------------------------------------------------------------------
  // scan code set 2 bytes and the ascii they decode to
  //----------------------------------------------------------------------

  typedef logic [7:0] scan_code_t;  // one byte from the keyboard
  typedef logic [7:0] ascii_t;      // one translated character

  // prefix bytes, never reported on their own
  localparam scan_code_t extend_code  = 8'he0;  // next code is an extended key
  localparam scan_code_t release_code = 8'hf0;  // next code is a key release

  // the two shift keys
  // tracked for upper case and optionally kept off the outputs
  localparam scan_code_t left_shift_code  = 8'h12;
  localparam scan_code_t right_shift_code = 8'h59;

  // any code missing from the lookup table reads as '.'
  localparam ascii_t ascii_unlisted = 8'h2e;

endpackage

// ==== verilog/scan_code_tracker.sv ====
`timescale 1ns/1ps

module scan_code_tracker
#(
  parameter int TRAP_SHIFT_KEYS = 0  // nonzero keeps shift keys off the outputs
)
(
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      frame_done,       // scan_code valid this cycle
  input  scan_code_pkg::scan_code_t scan_code,
  input  logic                      rx_read,          // host took the data
  output logic                      rx_extended,
  output logic                      rx_released,
  output logic                      rx_shift_key_on,
  output scan_code_pkg::scan_code_t rx_scan_code,
  output scan_code_pkg::ascii_t     rx_ascii,
  output logic                      rx_data_ready
);

  import scan_code_pkg::*;

  logic   is_extend;       // frame holds E0
  logic   is_release;      // frame holds F0
  logic   is_shift;        // frame holds either shift key
  logic   output_event;    // key code frame, clears the prefix flags
  logic   output_strobe;   // key code frame that reaches the outputs
  logic   hold_extended;   // E0 seen since the last key code
  logic   hold_released;   // F0 seen since the last key code
  logic   left_shift_key;
  logic   right_shift_key;
  ascii_t ascii;

  assign is_extend  = (scan_code == extend_code);
  assign is_release = (scan_code == release_code);
  assign is_shift   = (scan_code == left_shift_code) || (scan_code == right_shift_code);

  assign output_event  = frame_done && !is_extend && !is_release;
  assign output_strobe = output_event && ((TRAP_SHIFT_KEYS == 0) || !is_shift);

  //----------------------------------------------------------------------
  // prefix and shift state
  //----------------------------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (reset || output_event)  // a trapped shift key also ends the prefix run
    begin
      hold_extended <= 1'b0;
      hold_released <= 1'b0;
    end
    else if (frame_done)
    begin
      if (is_extend) hold_extended <= 1'b1;
      if (is_release) hold_released <= 1'b1;
    end
  end

  // make sets, F0-prefixed break clears
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      left_shift_key  <= 1'b0;
      right_shift_key <= 1'b0;
    end
    else if (frame_done)
    begin
      if (scan_code == left_shift_code) left_shift_key <= !hold_released;
      if (scan_code == right_shift_code) right_shift_key <= !hold_released;
    end
  end

  assign rx_shift_key_on = left_shift_key || right_shift_key;

  scan_code_ascii u_ascii
  (
    .scan_code    (scan_code),
    .shift_key_on (rx_shift_key_on),
    .ascii        (ascii)
  );

  //----------------------------------------------------------------------
  // output registers and data ready
  //----------------------------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      rx_extended  <= 1'b0;
      rx_released  <= 1'b0;
      rx_scan_code <= '0;
      rx_ascii     <= '0;
    end
    else if (output_strobe)  // overwrites unread data
    begin
      rx_extended  <= hold_extended;
      rx_released  <= hold_released;
      rx_scan_code <= scan_code;
      rx_ascii     <= ascii;
    end
  end

  always_ff @(posedge clk)
  begin
    if (reset)
      rx_data_ready <= 1'b0;
    else if (output_strobe)
      rx_data_ready <= 1'b1;  // new data wins over a read in the same cycle
    else if (rx_read)
      rx_data_ready <= 1'b0;
  end

endmodule
